//--- id2_settings.svh
`ifndef ID2_SETTINGS_SVH
`define ID2_SETTINGS_SVH

// operand and pc width
`define DATA_W      32

// register file index
`define REG_ADDR_W  5

// raw immediate field of I-type instructions
`define IMME_W      16

// shift amount field
`define SA_W        5

`endif

//--- id2_pkg.sv
package id2_pkg;

    // primary opcode field, MIPS values
    typedef enum logic [5:0] {
        op_special = 6'h00, op_regimm = 6'h01,
        op_j       = 6'h02, op_jal    = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05,
        op_blez    = 6'h06, op_bgtz   = 6'h07,
        op_addi    = 6'h08, op_addiu  = 6'h09,
        op_slti    = 6'h0a, op_sltiu  = 6'h0b,
        op_andi    = 6'h0c, op_ori    = 6'h0d,
        op_xori    = 6'h0e, op_lui    = 6'h0f,
        op_lb      = 6'h20, op_lh     = 6'h21,
        op_lw      = 6'h23, op_lbu    = 6'h24,
        op_lhu     = 6'h25, op_sb     = 6'h28,
        op_sh      = 6'h29, op_sw     = 6'h2b
    } op_code_e;

    // function field of special instructions
    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03,
        fn_sllv = 6'h04, fn_srlv = 6'h06, fn_srav = 6'h07,
        fn_jr   = 6'h08, fn_jalr = 6'h09,
        fn_add  = 6'h20, fn_addu = 6'h21, fn_sub  = 6'h22,
        fn_subu = 6'h23, fn_and  = 6'h24, fn_or   = 6'h25,
        fn_xor  = 6'h26, fn_nor  = 6'h27,
        fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_e;

    // rt field of regimm branches
    typedef enum logic [4:0] {
        rt_bltz   = 5'h00,
        rt_bgez   = 5'h01,
        rt_bltzal = 5'h10,
        rt_bgezal = 5'h11
    } regimm_rt_e;

    // bypass source, 7 is unused
    typedef enum logic [2:0] {
        fwd_nop, fwd_exc_alu, fwd_exp_alu, fwd_memc_alu,
        fwd_memc_mem, fwd_memp_alu, fwd_memp_mem
    } forward_sel_e;

    typedef enum logic [2:0] {
        src_a_rs, src_a_rt
    } src_a_sel_e;

    typedef enum logic [2:0] {
        src_b_nop, src_b_rt, src_b_imme, src_b_rs, src_b_sa
    } src_b_sel_e;

    typedef enum logic [5:0] {
        alu_nop, alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_sra, alu_srl, alu_lui
    } alu_sel_e;

    // pc_8 is the link value
    typedef enum logic [2:0] {
        res_alu, res_pc_8
    } alu_res_sel_e;

    typedef enum logic [3:0] {
        ls_nop, ls_lb, ls_lbu, ls_lh, ls_lhu,
        ls_lw, ls_sb, ls_sh, ls_sw
    } ls_sel_e;

endpackage

//--- id2_forward_mux.sv
`include "id2_settings.svh"

module id2_forward_mux import id2_pkg::*; (
    input  logic                clk,
    input  forward_sel_e        sel,
    input  logic [`DATA_W-1:0]  reg_data,
    input  logic [`DATA_W-1:0]  exc_alu_res,
    input  logic [`DATA_W-1:0]  exp_alu_res,
    input  logic [`DATA_W-1:0]  memc_alu_res,
    input  logic [`DATA_W-1:0]  memc_r_data,
    input  logic [`DATA_W-1:0]  memp_alu_res,
    input  logic [`DATA_W-1:0]  memp_r_data,
    output logic [`DATA_W-1:0]  data
);

    always_comb begin
        case (sel)
            fwd_nop:      data = reg_data;
            fwd_exc_alu:  data = exc_alu_res;
            fwd_exp_alu:  data = exp_alu_res;
            fwd_memc_alu: data = memc_alu_res;
            fwd_memc_mem: data = memc_r_data;
            fwd_memp_alu: data = memp_alu_res;
            fwd_memp_mem: data = memp_r_data;
            // encoding 7 never comes from the hazard unit
            default:      data = '0;
        endcase
    end

    // hazard unit only issues the seven defined selects
    a_sel_known: assert property (@(posedge clk)
        sel inside {fwd_nop, fwd_exc_alu, fwd_exp_alu, fwd_memc_alu,
                    fwd_memc_mem, fwd_memp_alu, fwd_memp_mem})
        else $error("forward select out of range: %0d", sel);

endmodule

//--- id2_branch_unit.sv
`include "id2_settings.svh"

module id2_branch_unit import id2_pkg::*; (
    input  logic                clk,
    input  op_code_e            op_code,
    input  regimm_rt_e          rt_code,
    input  logic                is_branch,
    input  logic                is_j_imme,
    input  logic                is_jr,
    input  logic [`DATA_W-1:0]  rs_data,
    input  logic [`DATA_W-1:0]  rt_data,
    output logic                take_branch,
    output logic                take_j_imme,
    output logic                take_jr,
    output logic                flush_req
);

    logic rs_eq_rt;
    logic rs_ltz;
    logic rs_eqz;
    logic cond;

    assign rs_eq_rt = (rs_data == rt_data);
    assign rs_ltz   = ($signed(rs_data) < 0);
    assign rs_eqz   = (rs_data == '0);

    // condition for the branch kind
    always_comb begin
        case (op_code)
            op_beq:  cond = rs_eq_rt;
            op_bne:  cond = !rs_eq_rt;
            op_blez: cond = rs_ltz || rs_eqz;
            op_bgtz: cond = !rs_ltz && !rs_eqz;
            op_regimm: begin
                case (rt_code)
                    rt_bltz, rt_bltzal: cond = rs_ltz;
                    rt_bgez, rt_bgezal: cond = !rs_ltz;
                    default:            cond = 1'b0;
                endcase
            end
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = is_branch && cond;
    assign take_j_imme = is_j_imme;
    assign take_jr     = is_jr;
    // redirect fetch and kill the younger slot
    assign flush_req   = take_branch || take_j_imme || take_jr;

    // stage 1 marks an instruction as one control-transfer kind only
    a_one_take: assert property (@(posedge clk)
        $onehot0({take_branch, take_j_imme, take_jr}))
        else $error("more than one take flag raised");

endmodule

//--- id2_decode.sv
`include "id2_settings.svh"

module id2_decode import id2_pkg::*; (
    input  op_code_e            op_code,
    input  funct_e              funct,
    input  regimm_rt_e          rt_code,
    input  logic [`IMME_W-1:0]  imme,
    output src_a_sel_e          src_a_sel,
    output src_b_sel_e          src_b_sel,
    output alu_sel_e            alu_sel,
    output alu_res_sel_e        alu_res_sel,
    output ls_sel_e             ls_sel,
    output logic                ls_ena,
    output logic                wb_reg_sel,
    output logic [`DATA_W-1:0]  ext_imme
);

    logic is_special;
    logic is_load;
    logic is_ls;
    logic is_alu_imme;
    logic sign_ext;

    assign is_special  = (op_code == op_special);
    assign is_load     = op_code inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
    assign is_ls       = is_load || (op_code inside {op_sb, op_sh, op_sw});
    assign is_alu_imme = op_code inside {op_addi, op_addiu, op_slti, op_sltiu,
                                         op_andi, op_ori, op_xori, op_lui};

    // shifts take the shifted value from rt
    always_comb begin
        if (is_special && funct inside {fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav}) begin
            src_a_sel = src_a_rt;
        end else begin
            src_a_sel = src_a_rs;
        end
    end

    always_comb begin
        if (is_special && funct inside {fn_add, fn_addu, fn_sub, fn_subu, fn_slt,
                                        fn_sltu, fn_and, fn_nor, fn_or, fn_xor}) begin
            src_b_sel = src_b_rt;
        end else if (is_alu_imme || is_ls) begin
            src_b_sel = src_b_imme;
        end else if (is_special && funct inside {fn_sllv, fn_srlv, fn_srav}) begin
            src_b_sel = src_b_rs;
        end else if (is_special && funct inside {fn_sll, fn_srl, fn_sra}) begin
            src_b_sel = src_b_sa;
        end else begin
            src_b_sel = src_b_nop;
        end
    end

    always_comb begin
        if (is_special) begin
            case (funct)
                fn_add, fn_addu: alu_sel = alu_add;
                fn_sub, fn_subu: alu_sel = alu_sub;
                fn_slt:          alu_sel = alu_slt;
                fn_sltu:         alu_sel = alu_sltu;
                fn_and:          alu_sel = alu_and;
                fn_nor:          alu_sel = alu_nor;
                fn_or:           alu_sel = alu_or;
                fn_xor:          alu_sel = alu_xor;
                fn_sll, fn_sllv: alu_sel = alu_sll;
                fn_sra, fn_srav: alu_sel = alu_sra;
                fn_srl, fn_srlv: alu_sel = alu_srl;
                default:         alu_sel = alu_nop;
            endcase
        end else begin
            case (op_code)
                // address add for every load and store
                op_addi, op_addiu, op_lb, op_lbu, op_lh, op_lhu,
                op_lw, op_sb, op_sh, op_sw: alu_sel = alu_add;
                op_slti:  alu_sel = alu_slt;
                op_sltiu: alu_sel = alu_sltu;
                op_andi:  alu_sel = alu_and;
                op_ori:   alu_sel = alu_or;
                op_xori:  alu_sel = alu_xor;
                op_lui:   alu_sel = alu_lui;
                default:  alu_sel = alu_nop;
            endcase
        end
    end

    // link instructions write pc+8
    always_comb begin
        if ((is_special && funct == fn_jalr) || op_code == op_jal ||
            (op_code == op_regimm && rt_code inside {rt_bltzal, rt_bgezal})) begin
            alu_res_sel = res_pc_8;
        end else begin
            alu_res_sel = res_alu;
        end
    end

    always_comb begin
        case (op_code)
            op_lb:   ls_sel = ls_lb;
            op_lbu:  ls_sel = ls_lbu;
            op_lh:   ls_sel = ls_lh;
            op_lhu:  ls_sel = ls_lhu;
            op_lw:   ls_sel = ls_lw;
            op_sb:   ls_sel = ls_sb;
            op_sh:   ls_sel = ls_sh;
            op_sw:   ls_sel = ls_sw;
            default: ls_sel = ls_nop;
        endcase
    end

    assign ls_ena     = (ls_sel != ls_nop);
    assign wb_reg_sel = is_load;

    // logic immediates and lui are zero extended
    assign sign_ext = is_ls || (op_code inside {op_addi, op_addiu, op_slti, op_sltiu});
    assign ext_imme = sign_ext ? {{(`DATA_W-`IMME_W){imme[`IMME_W-1]}}, imme}
                               : {{(`DATA_W-`IMME_W){1'b0}}, imme};

endmodule

//--- id2_ex_reg.sv
`include "id2_settings.svh"

module id2_ex_reg import id2_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    id1_valid,
    input  logic                    w_reg_ena,
    input  logic [`REG_ADDR_W-1:0]  w_reg_dst,
    input  logic [`DATA_W-1:0]      pc,
    input  logic [`SA_W-1:0]        sa,
    input  logic [`DATA_W-1:0]      rs_data,
    input  logic [`DATA_W-1:0]      rt_data,
    input  logic [`DATA_W-1:0]      ext_imme,
    input  src_a_sel_e              src_a_sel,
    input  src_b_sel_e              src_b_sel,
    input  alu_sel_e                alu_sel,
    input  alu_res_sel_e            alu_res_sel,
    input  ls_sel_e                 ls_sel,
    input  logic                    ls_ena,
    input  logic                    wb_reg_sel,
    output logic                    ex_valid,
    output logic                    ex_w_reg_ena,
    output logic [`REG_ADDR_W-1:0]  ex_w_reg_dst,
    output logic [`DATA_W-1:0]      ex_pc,
    output logic [`SA_W-1:0]        ex_sa,
    output logic [`DATA_W-1:0]      ex_rs_data,
    output logic [`DATA_W-1:0]      ex_rt_data,
    output logic [`DATA_W-1:0]      ex_ext_imme,
    output src_a_sel_e              ex_src_a_sel,
    output src_b_sel_e              ex_src_b_sel,
    output alu_sel_e                ex_alu_sel,
    output alu_res_sel_e            ex_alu_res_sel,
    output ls_sel_e                 ex_ls_sel,
    output logic                    ex_ls_ena,
    output logic                    ex_wb_reg_sel
);

    // control bundle
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid       <= 1'b0;
            ex_w_reg_ena   <= 1'b0;
            ex_ls_ena      <= 1'b0;
            ex_wb_reg_sel  <= 1'b0;
            ex_src_a_sel   <= src_a_rs;
            ex_src_b_sel   <= src_b_nop;
            ex_alu_sel     <= alu_nop;
            ex_alu_res_sel <= res_alu;
            ex_ls_sel      <= ls_nop;
        end else begin
            // a bubble must not write or touch memory
            ex_valid       <= id1_valid;
            ex_w_reg_ena   <= id1_valid && w_reg_ena;
            ex_ls_ena      <= id1_valid && ls_ena;
            ex_wb_reg_sel  <= wb_reg_sel;
            ex_src_a_sel   <= src_a_sel;
            ex_src_b_sel   <= src_b_sel;
            ex_alu_sel     <= alu_sel;
            ex_alu_res_sel <= alu_res_sel;
            ex_ls_sel      <= ls_sel;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        ex_w_reg_dst <= w_reg_dst;
        ex_pc        <= pc;
        ex_sa        <= sa;
        ex_rs_data   <= rs_data;
        ex_rt_data   <= rt_data;
        ex_ext_imme  <= ext_imme;
    end

endmodule

//--- idu_2.sv
`include "id2_settings.svh"

module idu_2 import id2_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    // stage 1
    input  logic                    id1_valid,
    input  logic [`DATA_W-1:0]      id1_pc,
    input  logic [5:0]              id1_op_code,
    input  logic [`REG_ADDR_W-1:0]  id1_rs,
    input  logic [`REG_ADDR_W-1:0]  id1_rt,
    input  logic [`SA_W-1:0]        id1_sa,
    input  logic [5:0]              id1_funct,
    input  logic                    id1_w_reg_ena,
    input  logic [`REG_ADDR_W-1:0]  id1_w_reg_dst,
    input  logic [`IMME_W-1:0]      id1_imme,
    input  logic                    id1_is_branch,
    input  logic                    id1_is_j_imme,
    input  logic                    id1_is_jr,
    // hazard unit and bypass network
    input  logic [2:0]              forward_rs,
    input  logic [2:0]              forward_rt,
    input  logic [`DATA_W-1:0]      exc_alu_res,
    input  logic [`DATA_W-1:0]      exp_alu_res,
    input  logic [`DATA_W-1:0]      memc_alu_res,
    input  logic [`DATA_W-1:0]      memc_r_data,
    input  logic [`DATA_W-1:0]      memp_alu_res,
    input  logic [`DATA_W-1:0]      memp_r_data,
    // register file
    output logic [`REG_ADDR_W-1:0]  reg_r_addr_1,
    output logic [`REG_ADDR_W-1:0]  reg_r_addr_2,
    input  logic [`DATA_W-1:0]      reg_r_data_1,
    input  logic [`DATA_W-1:0]      reg_r_data_2,
    // fetch redirect, same cycle
    output logic                    id2_take_branch,
    output logic                    id2_take_j_imme,
    output logic                    id2_take_jr,
    output logic                    id2_flush_req,
    // execute bundle
    output logic                    ex_valid,
    output logic                    ex_w_reg_ena,
    output logic [`REG_ADDR_W-1:0]  ex_w_reg_dst,
    output logic [`DATA_W-1:0]      ex_pc,
    output logic [`SA_W-1:0]        ex_sa,
    output logic [`DATA_W-1:0]      ex_rs_data,
    output logic [`DATA_W-1:0]      ex_rt_data,
    output logic [`DATA_W-1:0]      ex_ext_imme,
    output src_a_sel_e              ex_src_a_sel,
    output src_b_sel_e              ex_src_b_sel,
    output alu_sel_e                ex_alu_sel,
    output alu_res_sel_e            ex_alu_res_sel,
    output ls_sel_e                 ex_ls_sel,
    output logic                    ex_ls_ena,
    output logic                    ex_wb_reg_sel
);

    logic [`DATA_W-1:0] rs_data;
    logic [`DATA_W-1:0] rt_data;
    logic [`DATA_W-1:0] ext_imme;
    src_a_sel_e         src_a_sel;
    src_b_sel_e         src_b_sel;
    alu_sel_e           alu_sel;
    alu_res_sel_e       alu_res_sel;
    ls_sel_e            ls_sel;
    logic               ls_ena;
    logic               wb_reg_sel;

    assign reg_r_addr_1 = id1_rs;
    assign reg_r_addr_2 = id1_rt;

    id2_forward_mux u_fwd_rs (
        .clk          (clk),
        .sel          (forward_sel_e'(forward_rs)),
        .reg_data     (reg_r_data_1),
        .exc_alu_res  (exc_alu_res),
        .exp_alu_res  (exp_alu_res),
        .memc_alu_res (memc_alu_res),
        .memc_r_data  (memc_r_data),
        .memp_alu_res (memp_alu_res),
        .memp_r_data  (memp_r_data),
        .data         (rs_data)
    );

    id2_forward_mux u_fwd_rt (
        .clk          (clk),
        .sel          (forward_sel_e'(forward_rt)),
        .reg_data     (reg_r_data_2),
        .exc_alu_res  (exc_alu_res),
        .exp_alu_res  (exp_alu_res),
        .memc_alu_res (memc_alu_res),
        .memc_r_data  (memc_r_data),
        .memp_alu_res (memp_alu_res),
        .memp_r_data  (memp_r_data),
        .data         (rt_data)
    );

    id2_branch_unit u_branch (
        .clk         (clk),
        .op_code     (op_code_e'(id1_op_code)),
        .rt_code     (regimm_rt_e'(id1_rt)),
        .is_branch   (id1_is_branch),
        .is_j_imme   (id1_is_j_imme),
        .is_jr       (id1_is_jr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .take_branch (id2_take_branch),
        .take_j_imme (id2_take_j_imme),
        .take_jr     (id2_take_jr),
        .flush_req   (id2_flush_req)
    );

    id2_decode u_decode (
        .op_code     (op_code_e'(id1_op_code)),
        .funct       (funct_e'(id1_funct)),
        .rt_code     (regimm_rt_e'(id1_rt)),
        .imme        (id1_imme),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .alu_sel     (alu_sel),
        .alu_res_sel (alu_res_sel),
        .ls_sel      (ls_sel),
        .ls_ena      (ls_ena),
        .wb_reg_sel  (wb_reg_sel),
        .ext_imme    (ext_imme)
    );

    id2_ex_reg u_ex_reg (
        .clk            (clk),
        .reset          (reset),
        .id1_valid      (id1_valid),
        .w_reg_ena      (id1_w_reg_ena),
        .w_reg_dst      (id1_w_reg_dst),
        .pc             (id1_pc),
        .sa             (id1_sa),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .ext_imme       (ext_imme),
        .src_a_sel      (src_a_sel),
        .src_b_sel      (src_b_sel),
        .alu_sel        (alu_sel),
        .alu_res_sel    (alu_res_sel),
        .ls_sel         (ls_sel),
        .ls_ena         (ls_ena),
        .wb_reg_sel     (wb_reg_sel),
        .ex_valid       (ex_valid),
        .ex_w_reg_ena   (ex_w_reg_ena),
        .ex_w_reg_dst   (ex_w_reg_dst),
        .ex_pc          (ex_pc),
        .ex_sa          (ex_sa),
        .ex_rs_data     (ex_rs_data),
        .ex_rt_data     (ex_rt_data),
        .ex_ext_imme    (ex_ext_imme),
        .ex_src_a_sel   (ex_src_a_sel),
        .ex_src_b_sel   (ex_src_b_sel),
        .ex_alu_sel     (ex_alu_sel),
        .ex_alu_res_sel (ex_alu_res_sel),
        .ex_ls_sel      (ex_ls_sel),
        .ex_ls_ena      (ex_ls_ena),
        .ex_wb_reg_sel  (ex_wb_reg_sel)
    );

endmodule

//--- tb_idu_2.sv
`include "id2_settings.svh"

module tb_idu_2 import id2_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_VECTORS    = 2000;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS + 100;

    typedef struct packed {
        logic                   valid;
        logic                   w_ena;
        logic [`REG_ADDR_W-1:0] dst;
        logic [`DATA_W-1:0]     pc;
        logic [`SA_W-1:0]       sa;
        logic [`DATA_W-1:0]     rs;
        logic [`DATA_W-1:0]     rt;
        logic [`DATA_W-1:0]     imme;
        src_a_sel_e             src_a;
        src_b_sel_e             src_b;
        alu_sel_e               alu;
        alu_res_sel_e           res;
        ls_sel_e                ls;
        logic                   ls_ena;
        logic                   wb;
    } ex_exp_t;

    logic clk;
    logic reset;
    logic id1_valid;
    logic [`DATA_W-1:0] id1_pc;
    logic [5:0] id1_op_code;
    logic [`REG_ADDR_W-1:0] id1_rs;
    logic [`REG_ADDR_W-1:0] id1_rt;
    logic [`SA_W-1:0] id1_sa;
    logic [5:0] id1_funct;
    logic id1_w_reg_ena;
    logic [`REG_ADDR_W-1:0] id1_w_reg_dst;
    logic [`IMME_W-1:0] id1_imme;
    logic id1_is_branch;
    logic id1_is_j_imme;
    logic id1_is_jr;
    logic [2:0] forward_rs;
    logic [2:0] forward_rt;
    logic [`DATA_W-1:0] exc_alu_res;
    logic [`DATA_W-1:0] exp_alu_res;
    logic [`DATA_W-1:0] memc_alu_res;
    logic [`DATA_W-1:0] memc_r_data;
    logic [`DATA_W-1:0] memp_alu_res;
    logic [`DATA_W-1:0] memp_r_data;
    logic [`DATA_W-1:0] reg_r_data_1;
    logic [`DATA_W-1:0] reg_r_data_2;
    logic [`REG_ADDR_W-1:0] reg_r_addr_1;
    logic [`REG_ADDR_W-1:0] reg_r_addr_2;
    logic id2_take_branch;
    logic id2_take_j_imme;
    logic id2_take_jr;
    logic id2_flush_req;
    logic ex_valid;
    logic ex_w_reg_ena;
    logic [`REG_ADDR_W-1:0] ex_w_reg_dst;
    logic [`DATA_W-1:0] ex_pc;
    logic [`SA_W-1:0] ex_sa;
    logic [`DATA_W-1:0] ex_rs_data;
    logic [`DATA_W-1:0] ex_rt_data;
    logic [`DATA_W-1:0] ex_ext_imme;
    src_a_sel_e ex_src_a_sel;
    src_b_sel_e ex_src_b_sel;
    alu_sel_e ex_alu_sel;
    alu_res_sel_e ex_alu_res_sel;
    ls_sel_e ex_ls_sel;
    logic ex_ls_ena;
    logic ex_wb_reg_sel;

    logic [31:0] lfsr;
    int comb_errors;
    int reg_errors;
    int cycles;
    ex_exp_t exp_q[$];
    op_code_e op_table [24];
    funct_e funct_table [18];
    regimm_rt_e rt_table [4];

    idu_2 u_dut (.*);

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`DATA_W-1:0] fwd_value(input logic [2:0] sel,
                                                      input logic [`DATA_W-1:0] reg_v);
        case (sel)
            3'd0: return reg_v;
            3'd1: return exc_alu_res;
            3'd2: return exp_alu_res;
            3'd3: return memc_alu_res;
            3'd4: return memc_r_data;
            3'd5: return memp_alu_res;
            3'd6: return memp_r_data;
            default: return '0;
        endcase
    endfunction

    function automatic logic model_take(input logic [`DATA_W-1:0] rs_v,
                                        input logic [`DATA_W-1:0] rt_v);
        logic signed [`DATA_W-1:0] s;
        s = rs_v;
        if (!id1_is_branch) return 1'b0;
        case (id1_op_code)
            op_beq:  return rs_v == rt_v;
            op_bne:  return rs_v != rt_v;
            op_blez: return s <= 0;
            op_bgtz: return s > 0;
            // rt bit 0 picks the greater-or-equal form
            op_regimm: return id1_rt[0] ? (s >= 0) : (s < 0);
            default: return 1'b0;
        endcase
    endfunction

    function automatic ex_exp_t model_ex();
        ex_exp_t e;
        logic sign_ext;
        e = '0;
        sign_ext = 1'b0;
        e.valid = id1_valid;
        e.w_ena = id1_valid && id1_w_reg_ena;
        e.dst = id1_w_reg_dst;
        e.pc = id1_pc;
        e.sa = id1_sa;
        e.rs = fwd_value(forward_rs, reg_r_data_1);
        e.rt = fwd_value(forward_rt, reg_r_data_2);
        if (id1_op_code == op_special) begin
            case (id1_funct)
                fn_sll, fn_srl, fn_sra: begin
                    e.src_a = src_a_rt;
                    e.src_b = src_b_sa;
                end
                fn_sllv, fn_srlv, fn_srav: begin
                    e.src_a = src_a_rt;
                    e.src_b = src_b_rs;
                end
                fn_jr, fn_jalr: e.src_b = src_b_nop;
                default: e.src_b = src_b_rt;
            endcase
            case (id1_funct)
                fn_add, fn_addu: e.alu = alu_add;
                fn_sub, fn_subu: e.alu = alu_sub;
                fn_slt:          e.alu = alu_slt;
                fn_sltu:         e.alu = alu_sltu;
                fn_and:          e.alu = alu_and;
                fn_or:           e.alu = alu_or;
                fn_xor:          e.alu = alu_xor;
                fn_nor:          e.alu = alu_nor;
                fn_sll, fn_sllv: e.alu = alu_sll;
                fn_srl, fn_srlv: e.alu = alu_srl;
                fn_sra, fn_srav: e.alu = alu_sra;
                default:         e.alu = alu_nop;
            endcase
            if (id1_funct == fn_jalr) e.res = res_pc_8;
        end else begin
            case (id1_op_code)
                op_addi, op_addiu: e.alu = alu_add;
                op_slti:  e.alu = alu_slt;
                op_sltiu: e.alu = alu_sltu;
                op_andi:  e.alu = alu_and;
                op_ori:   e.alu = alu_or;
                op_xori:  e.alu = alu_xor;
                op_lui:   e.alu = alu_lui;
                op_lb:    e.ls = ls_lb;
                op_lbu:   e.ls = ls_lbu;
                op_lh:    e.ls = ls_lh;
                op_lhu:   e.ls = ls_lhu;
                op_lw:    e.ls = ls_lw;
                op_sb:    e.ls = ls_sb;
                op_sh:    e.ls = ls_sh;
                op_sw:    e.ls = ls_sw;
                default:  ;
            endcase
            if (e.ls != ls_nop) e.alu = alu_add;
            if (e.alu != alu_nop) e.src_b = src_b_imme;
            // arithmetic and address immediates are signed
            sign_ext = (e.alu == alu_add) || (e.alu == alu_slt) || (e.alu == alu_sltu);
            if (id1_op_code == op_jal) e.res = res_pc_8;
            if (id1_op_code == op_regimm && (id1_rt == rt_bltzal || id1_rt == rt_bgezal))
                e.res = res_pc_8;
        end
        e.ls_ena = id1_valid && (e.ls != ls_nop);
        // loads sit at 0x20..0x27
        e.wb = (id1_op_code[5:3] == 3'b100);
        e.imme = sign_ext ? {{(`DATA_W-`IMME_W){id1_imme[`IMME_W-1]}}, id1_imme}
                          : {{(`DATA_W-`IMME_W){1'b0}}, id1_imme};
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v, input bit registered);
        assert (act_v === exp_v) else begin
            $display("ERROR %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
            if (registered) reg_errors++;
            else comb_errors++;
        end
    endtask

    task automatic check_comb();
        logic take_exp;
        take_exp = model_take(fwd_value(forward_rs, reg_r_data_1),
                              fwd_value(forward_rt, reg_r_data_2));
        check_value("reg_r_addr_1", id1_rs, reg_r_addr_1, 1'b0);
        check_value("reg_r_addr_2", id1_rt, reg_r_addr_2, 1'b0);
        check_value("id2_take_branch", take_exp, id2_take_branch, 1'b0);
        check_value("id2_take_j_imme", id1_is_j_imme, id2_take_j_imme, 1'b0);
        check_value("id2_take_jr", id1_is_jr, id2_take_jr, 1'b0);
        check_value("id2_flush_req", take_exp || id1_is_j_imme || id1_is_jr,
                    id2_flush_req, 1'b0);
    endtask

    task automatic check_registered(input ex_exp_t e);
        check_value("ex_valid", e.valid, ex_valid, 1'b1);
        check_value("ex_w_reg_ena", e.w_ena, ex_w_reg_ena, 1'b1);
        check_value("ex_w_reg_dst", e.dst, ex_w_reg_dst, 1'b1);
        check_value("ex_pc", e.pc, ex_pc, 1'b1);
        check_value("ex_sa", e.sa, ex_sa, 1'b1);
        check_value("ex_rs_data", e.rs, ex_rs_data, 1'b1);
        check_value("ex_rt_data", e.rt, ex_rt_data, 1'b1);
        check_value("ex_ext_imme", e.imme, ex_ext_imme, 1'b1);
        check_value("ex_src_a_sel", e.src_a, ex_src_a_sel, 1'b1);
        check_value("ex_src_b_sel", e.src_b, ex_src_b_sel, 1'b1);
        check_value("ex_alu_sel", e.alu, ex_alu_sel, 1'b1);
        check_value("ex_alu_res_sel", e.res, ex_alu_res_sel, 1'b1);
        check_value("ex_ls_sel", e.ls, ex_ls_sel, 1'b1);
        check_value("ex_ls_ena", e.ls_ena, ex_ls_ena, 1'b1);
        check_value("ex_wb_reg_sel", e.wb, ex_wb_reg_sel, 1'b1);
    endtask

    task automatic drive_vector(input int idx);
        logic [`DATA_W-1:0] fill;
        id1_valid = (take_bits(3) != 0);
        id1_pc = take_bits(32);
        if (take_bits(2) == 0) id1_op_code = op_special;
        else id1_op_code = op_table[take_bits(5) % 24];
        if (id1_op_code == op_special) id1_funct = funct_table[take_bits(5) % 18];
        else id1_funct = take_bits(6);
        if (id1_op_code == op_regimm) id1_rt = rt_table[take_bits(2)];
        else id1_rt = take_bits(5);
        id1_rs = take_bits(5);
        id1_sa = take_bits(5);
        id1_w_reg_ena = take_bits(1);
        id1_w_reg_dst = take_bits(5);
        id1_imme = take_bits(16);
        id1_is_branch = 1'b0;
        id1_is_j_imme = 1'b0;
        id1_is_jr = 1'b0;
        // stage 1 sometimes withholds the branch flag
        case (id1_op_code)
            op_beq, op_bne, op_blez, op_bgtz, op_regimm: id1_is_branch = (take_bits(2) != 0);
            op_j, op_jal: id1_is_j_imme = 1'b1;
            op_special: id1_is_jr = (id1_funct == fn_jr) || (id1_funct == fn_jalr);
            default: ;
        endcase
        forward_rs = take_bits(8) % 7;
        forward_rt = take_bits(8) % 7;
        reg_r_data_1 = take_bits(32);
        reg_r_data_2 = take_bits(32);
        exc_alu_res = take_bits(32);
        exp_alu_res = take_bits(32);
        memc_alu_res = take_bits(32);
        memc_r_data = take_bits(32);
        memp_alu_res = take_bits(32);
        memp_r_data = take_bits(32);
        // equal or zero operands for the branch edges
        if (idx % 4 == 3) begin
            fill = take_bits(1) ? '0 : take_bits(32);
            reg_r_data_1 = fill;
            reg_r_data_2 = fill;
            exc_alu_res = fill;
            exp_alu_res = fill;
            memc_alu_res = fill;
            memc_r_data = fill;
            memp_alu_res = fill;
            memp_r_data = fill;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        op_table = '{op_special, op_regimm, op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz,
                     op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui,
                     op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
        funct_table = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav, fn_jr, fn_jalr,
                        fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                        fn_slt, fn_sltu};
        rt_table = '{rt_bltz, rt_bgez, rt_bltzal, rt_bgezal};
        lfsr = 32'h3be399b0;
        comb_errors = 0;
        reg_errors = 0;
        clk = 1'b0;
        reset = 1'b1;
        id1_valid = 1'b1;
        id1_pc = '0;
        // a valid load during reset, so every cleared field would otherwise be set
        id1_op_code = op_lw;
        id1_rs = '0;
        id1_rt = '0;
        id1_sa = '0;
        id1_funct = '0;
        id1_w_reg_ena = 1'b1;
        id1_w_reg_dst = '0;
        id1_imme = '0;
        id1_is_branch = 1'b0;
        id1_is_j_imme = 1'b0;
        id1_is_jr = 1'b0;
        forward_rs = '0;
        forward_rt = '0;
        exc_alu_res = '0;
        exp_alu_res = '0;
        memc_alu_res = '0;
        memc_r_data = '0;
        memp_alu_res = '0;
        memp_r_data = '0;
        reg_r_data_1 = '0;
        reg_r_data_2 = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("ex_valid", 1'b0, ex_valid, 1'b1);
        check_value("ex_w_reg_ena", 1'b0, ex_w_reg_ena, 1'b1);
        check_value("ex_ls_ena", 1'b0, ex_ls_ena, 1'b1);
        check_value("ex_wb_reg_sel", 1'b0, ex_wb_reg_sel, 1'b1);
        check_value("ex_alu_sel", alu_nop, ex_alu_sel, 1'b1);
        check_value("ex_ls_sel", ls_nop, ex_ls_sel, 1'b1);
        reset = 1'b0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (exp_q.size() > 0) check_registered(exp_q.pop_front());
            drive_vector(i);
            #2;
            check_comb();
            exp_q.push_back(model_ex());
            @(negedge clk);
        end
        check_registered(exp_q.pop_front());
        $display("errors: combinational %0d, registered %0d, total %0d",
                 comb_errors, reg_errors, comb_errors + reg_errors);
        if (comb_errors + reg_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- idu_2.f
+incdir+.
id2_pkg.sv
id2_forward_mux.sv
id2_branch_unit.sv
id2_decode.sv
id2_ex_reg.sv
idu_2.sv
tb_idu_2.sv
